//--- rtl/rv_decode_params.svh
/* RV32I decode stage widths */

`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Datapath and PC width
`define RV_XLEN 32

// Register file address width
`define RV_REG_AW 5

// Control field widths
`define RV_ALU_OP_W 4
`define RV_LSU_CTRL_W 4

// Instruction field widths
`define RV_OPCODE_W 7
`define RV_FUNCT3_W 3

// Encoded widths of the format select and the sequencer state
`define RV_IMM_FMT_W 3
`define RV_STATE_W 3

// Return address is PC plus one instruction
`define RV_LINK_OFFSET 4

`endif

//--- rtl/rv_decode_pkg.sv
/* RV32I decode types */

`include "rv_decode_params.svh"

package rv_decode_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPC_LOAD  = 7'b0000011,
    OPC_OPIMM = 7'b0010011,
    OPC_AUIPC = 7'b0010111,
    OPC_STORE = 7'b0100011,
    OPC_OP    = 7'b0110011,
    OPC_LUI   = 7'b0110111,
    OPC_JALR  = 7'b1100111,
    OPC_JAL   = 7'b1101111
  } opcode_e;

  // ALU select is {instr[30], funct3}
  typedef enum logic [`RV_ALU_OP_W-1:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [`RV_IMM_FMT_W-1:0] {
    IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_U, IMM_J, IMM_LINK
  } imm_fmt_e;

  typedef enum logic [`RV_STATE_W-1:0] {
    ST_RUN, ST_STALL, ST_JAL, ST_JALR_LINK, ST_JALR_ADDR, ST_JALR_JMP, ST_ERROR
  } issue_state_e;

  typedef struct packed {
    opcode_e                           opcode;
    logic [`RV_REG_AW-1:0]             rd;
    logic [`RV_REG_AW-1:0]             rs1;
    logic [`RV_REG_AW-1:0]             rs2;
    logic [`RV_FUNCT3_W-1:0]           funct3;
    logic                              bit30;
    logic [`RV_XLEN-`RV_OPCODE_W-1:0]  upper;  // instr[31:7]
  } instr_fields_t;

  typedef struct packed {
    alu_op_e               alu_sel;
    logic                  op_a;              // Operand A read from rf_addr_a
    logic                  op_b;              // Operand B read from rf_addr_b
    logic [`RV_REG_AW-1:0] dest_addr;
    logic                  wb;
    logic                  use_pc;
    logic                  use_alu_jmp_addr;
    logic [`RV_REG_AW-1:0] rf_addr_a;
    logic [`RV_REG_AW-1:0] rf_addr_b;
    logic                  is_imm;
    logic [`RV_XLEN-1:0]   imm_ext;
  } alu_ctrl_t;

  typedef struct packed {
    logic                      new_req;
    logic [`RV_LSU_CTRL_W-1:0] ctrl;         // {opcode[6], funct3}
    logic [`RV_REG_AW-1:0]     regdest;
  } lsu_ctrl_t;

endpackage

//--- rtl/imm_gen.sv
/* Immediate generator */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module imm_gen (
  input  rv_decode_pkg::instr_fields_t fields_i,
  input  rv_decode_pkg::imm_fmt_e      fmt_i,
  output logic [`RV_XLEN-1:0]          imm_o,
  output logic [`RV_XLEN-1:0]          j_imm_o
);

  logic [`RV_XLEN-1:0] iw;      // Instruction word rebuilt from the fields
  logic [`RV_XLEN-1:0] i_imm;
  logic [`RV_XLEN-1:0] sh_imm;
  logic [`RV_XLEN-1:0] s_imm;
  logic [`RV_XLEN-1:0] u_imm;
  logic [`RV_XLEN-1:0] j_imm;

  assign iw = {fields_i.upper, fields_i.opcode};

  ////////////////////////////////////////////////////////////
  // Per-format immediates
  ////////////////////////////////////////////////////////////
  assign i_imm  = {{(`RV_XLEN-12){iw[31]}}, iw[31:20]};
  assign sh_imm = {{(`RV_XLEN-5){1'b0}}, iw[24:20]};              // Zero-extended shamt
  assign s_imm  = {{(`RV_XLEN-12){iw[31]}}, iw[31:25], iw[11:7]};
  assign u_imm  = {iw[31:12], 12'b0};
  assign j_imm  = {{(`RV_XLEN-21){iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};

  always_comb begin
    case (fmt_i)
      rv_decode_pkg::IMM_I:     imm_o = i_imm;
      rv_decode_pkg::IMM_SHAMT: imm_o = sh_imm;
      rv_decode_pkg::IMM_S:     imm_o = s_imm;
      rv_decode_pkg::IMM_U:     imm_o = u_imm;
      rv_decode_pkg::IMM_J:     imm_o = j_imm;
      rv_decode_pkg::IMM_LINK:  imm_o = `RV_XLEN'(`RV_LINK_OFFSET);
      default:                  imm_o = '0;
    endcase
  end

  assign j_imm_o = j_imm;  // Jump target offset for fetch

endmodule

//--- rtl/hazard_detect.sv
/* Read-after-write detector */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module hazard_detect (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  rv_decode_pkg::instr_fields_t fields_i,
  input  logic                         accept_i,
  output logic                         stall_req_o
);

  logic [`RV_REG_AW-1:0] last_rd_q;  // rd of the last accepted instruction
  logic                  stalled_q;
  logic                  rs1_used;
  logic                  rs2_used;
  logic                  rs1_hit;
  logic                  rs2_hit;

  always_comb begin
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (fields_i.opcode)
      rv_decode_pkg::OPC_LOAD,
      rv_decode_pkg::OPC_STORE,
      rv_decode_pkg::OPC_OPIMM: rs1_used = 1'b1;
      rv_decode_pkg::OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      default: ;
    endcase
  end

  assign rs1_hit = rs1_used && (fields_i.rs1 == last_rd_q) && (last_rd_q != '0);
  assign rs2_hit = rs2_used && (fields_i.rs2 == last_rd_q) && (last_rd_q != '0);

  // Never two stalls back to back
  assign stall_req_o = (rs1_hit || rs2_hit) && !stalled_q;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      last_rd_q <= '0;
      stalled_q <= 1'b0;
    end else begin
      stalled_q <= stall_req_o;
      if (accept_i) begin
        last_rd_q <= (fields_i.opcode == rv_decode_pkg::OPC_STORE) ? '0 : fields_i.rd;
      end
    end
  end

endmodule

//--- rtl/issue_fsm.sv
/* Issue sequencer */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module issue_fsm (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  rv_decode_pkg::instr_fields_t fields_i,
  input  logic                         valid_i,
  input  logic                         stall_req_i,
  input  logic [`RV_XLEN-1:0]          j_imm_i,
  output rv_decode_pkg::issue_state_e  state_o,
  output logic                         accept_o,
  output logic                         ready_o,
  output logic                         jmp_o,
  output logic [`RV_XLEN-1:0]          jmp_addr_o
);

  rv_decode_pkg::issue_state_e prev_q;  // Step taken in the last cycle

  ////////////////////////////////////////////////////////////
  // Current step
  ////////////////////////////////////////////////////////////
  always_comb begin
    if (!valid_i) begin
      state_o = rv_decode_pkg::ST_RUN;  // Idle
    end else begin
      case (fields_i.opcode)
        rv_decode_pkg::OPC_LOAD,
        rv_decode_pkg::OPC_STORE,
        rv_decode_pkg::OPC_OPIMM,
        rv_decode_pkg::OPC_OP: begin
          state_o = stall_req_i ? rv_decode_pkg::ST_STALL : rv_decode_pkg::ST_RUN;
        end
        rv_decode_pkg::OPC_LUI,
        rv_decode_pkg::OPC_AUIPC: state_o = rv_decode_pkg::ST_RUN;
        rv_decode_pkg::OPC_JAL:   state_o = rv_decode_pkg::ST_JAL;
        rv_decode_pkg::OPC_JALR: begin
          // Link, then target, then jump
          case (prev_q)
            rv_decode_pkg::ST_JALR_LINK: state_o = rv_decode_pkg::ST_JALR_ADDR;
            rv_decode_pkg::ST_JALR_ADDR: state_o = rv_decode_pkg::ST_JALR_JMP;
            default:                     state_o = rv_decode_pkg::ST_JALR_LINK;
          endcase
        end
        default: state_o = rv_decode_pkg::ST_ERROR;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      prev_q <= rv_decode_pkg::ST_RUN;
    end else begin
      prev_q <= state_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (state_o)
      rv_decode_pkg::ST_RUN,
      rv_decode_pkg::ST_JAL,
      rv_decode_pkg::ST_JALR_JMP: ready_o = 1'b1;
      default:                    ready_o = 1'b0;
    endcase
  end

  assign jmp_o      = (state_o == rv_decode_pkg::ST_JAL);
  assign jmp_addr_o = jmp_o ? j_imm_i : '0;
  assign accept_o   = valid_i && ready_o;  // Fetch may advance

endmodule

//--- rtl/ctrl_decode.sv
/* Control decode table */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module ctrl_decode (
  input  logic                         clk_i,
  input  logic                         rstn_i,
  input  rv_decode_pkg::instr_fields_t fields_i,
  input  logic                         valid_i,
  input  rv_decode_pkg::issue_state_e  state_i,
  input  logic [`RV_XLEN-1:0]          imm_i,
  input  logic [`RV_XLEN-1:0]          instr_addr_i,
  output rv_decode_pkg::imm_fmt_e      fmt_o,
  output logic [`RV_XLEN-1:0]          instr_addr_o,
  output logic                         illegal_o,
  output rv_decode_pkg::alu_ctrl_t     alu_o,
  output rv_decode_pkg::lsu_ctrl_t     lsu_o
);

  rv_decode_pkg::alu_ctrl_t alu_d;
  rv_decode_pkg::lsu_ctrl_t lsu_d;
  logic                     illegal_d;
  logic                     is_shift;

  assign is_shift = (fields_i.funct3[1:0] == 2'b01);  // SLLI, SRLI, SRAI

  ////////////////////////////////////////////////////////////
  // Opcode and step to control
  ////////////////////////////////////////////////////////////
  always_comb begin
    alu_d         = '0;
    alu_d.alu_sel = rv_decode_pkg::ALU_ADD;
    lsu_d.new_req = 1'b0;
    lsu_d.ctrl    = {fields_i.opcode[6], fields_i.funct3};
    lsu_d.regdest = fields_i.rd;
    illegal_d     = 1'b0;
    fmt_o         = rv_decode_pkg::IMM_NONE;

    case (state_i)
      rv_decode_pkg::ST_STALL: ;            // Bubble
      rv_decode_pkg::ST_ERROR: illegal_d = 1'b1;
      rv_decode_pkg::ST_JAL,
      rv_decode_pkg::ST_JALR_LINK: begin   // rd = PC + 4
        alu_d.use_pc    = 1'b1;
        alu_d.dest_addr = fields_i.rd;
        alu_d.wb        = 1'b1;
        fmt_o           = rv_decode_pkg::IMM_LINK;
      end
      rv_decode_pkg::ST_JALR_ADDR: begin   // rs1 + offset
        alu_d.op_a      = 1'b1;
        alu_d.rf_addr_a = fields_i.rs1;
        fmt_o           = rv_decode_pkg::IMM_I;
      end
      rv_decode_pkg::ST_JALR_JMP: alu_d.use_alu_jmp_addr = 1'b1;
      default: begin
        case (fields_i.opcode)
          rv_decode_pkg::OPC_LOAD,
          rv_decode_pkg::OPC_STORE: begin
            alu_d.op_a      = 1'b1;
            alu_d.rf_addr_a = fields_i.rs1;
            lsu_d.new_req   = 1'b1;
            fmt_o = (fields_i.opcode == rv_decode_pkg::OPC_STORE) ?
                    rv_decode_pkg::IMM_S : rv_decode_pkg::IMM_I;
          end
          rv_decode_pkg::OPC_OPIMM: begin
            alu_d.op_a      = 1'b1;
            alu_d.rf_addr_a = fields_i.rs1;
            alu_d.dest_addr = fields_i.rd;
            alu_d.wb        = 1'b1;
            if (is_shift) begin
              alu_d.alu_sel = rv_decode_pkg::alu_op_e'({fields_i.bit30, fields_i.funct3});
              fmt_o         = rv_decode_pkg::IMM_SHAMT;
            end else begin
              alu_d.alu_sel = rv_decode_pkg::alu_op_e'({1'b0, fields_i.funct3});
              fmt_o         = rv_decode_pkg::IMM_I;
            end
          end
          rv_decode_pkg::OPC_OP: begin
            alu_d.alu_sel   = rv_decode_pkg::alu_op_e'({fields_i.bit30, fields_i.funct3});
            alu_d.op_a      = 1'b1;
            alu_d.op_b      = 1'b1;
            alu_d.rf_addr_a = fields_i.rs1;
            alu_d.rf_addr_b = fields_i.rs2;
            alu_d.dest_addr = fields_i.rd;
            alu_d.wb        = 1'b1;
          end
          rv_decode_pkg::OPC_LUI,
          rv_decode_pkg::OPC_AUIPC: begin  // x0 or PC plus upper immediate
            alu_d.op_a      = 1'b1;
            alu_d.use_pc    = (fields_i.opcode == rv_decode_pkg::OPC_AUIPC);
            alu_d.dest_addr = fields_i.rd;
            alu_d.wb        = 1'b1;
            fmt_o           = rv_decode_pkg::IMM_U;
          end
          default: ;
        endcase
      end
    endcase

    alu_d.is_imm  = !(alu_d.op_a && alu_d.op_b);
    alu_d.imm_ext = imm_i;
  end

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      alu_o     <= '0;
      lsu_o     <= '0;
      illegal_o <= 1'b0;
    end else if (valid_i) begin
      alu_o     <= alu_d;
      lsu_o     <= lsu_d;
      illegal_o <= illegal_d;
    end else begin
      alu_o.use_pc           <= 1'b0;  // Only the PC-related pulses drop
      alu_o.use_alu_jmp_addr <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    instr_addr_o <= instr_addr_i;
  end

endmodule

//--- rtl/rv_decoder.sv
/* RV32I decode stage */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decoder (
  input  logic                     clk_i,
  input  logic                     rstn_i,
  input  logic [`RV_XLEN-1:0]      instr_i,
  input  logic [`RV_XLEN-1:0]      instr_addr_i,
  input  logic                     instr_valid_i,
  output logic                     ready_o,
  output logic                     jmp_o,
  output logic [`RV_XLEN-1:0]      jmp_addr_o,
  output logic [`RV_XLEN-1:0]      instr_addr_o,
  output logic                     illegal_o,
  output rv_decode_pkg::alu_ctrl_t alu_o,
  output rv_decode_pkg::lsu_ctrl_t lsu_o
);

  rv_decode_pkg::instr_fields_t fields;
  rv_decode_pkg::issue_state_e  state;
  rv_decode_pkg::imm_fmt_e      fmt;
  logic                         stall_req;
  logic                         accept;
  logic [`RV_XLEN-1:0]          imm;
  logic [`RV_XLEN-1:0]          j_imm;

  // Field split
  always_comb begin
    fields.opcode = rv_decode_pkg::opcode_e'(instr_i[6:0]);
    fields.rd     = instr_i[11:7];
    fields.rs1    = instr_i[19:15];
    fields.rs2    = instr_i[24:20];
    fields.funct3 = instr_i[14:12];
    fields.bit30  = instr_i[30];
    fields.upper  = instr_i[31:7];
  end

  hazard_detect u_hazard (
    .clk_i, .rstn_i, .fields_i(fields), .accept_i(accept), .stall_req_o(stall_req)
  );

  issue_fsm u_issue (
    .clk_i, .rstn_i, .fields_i(fields), .valid_i(instr_valid_i),
    .stall_req_i(stall_req), .j_imm_i(j_imm), .state_o(state), .accept_o(accept),
    .ready_o, .jmp_o, .jmp_addr_o
  );

  ctrl_decode u_ctrl (
    .clk_i, .rstn_i, .fields_i(fields), .valid_i(instr_valid_i), .state_i(state),
    .imm_i(imm), .instr_addr_i, .fmt_o(fmt), .instr_addr_o, .illegal_o, .alu_o, .lsu_o
  );

  imm_gen u_imm (
    .fields_i(fields), .fmt_i(fmt), .imm_o(imm), .j_imm_o(j_imm)
  );

endmodule

//--- verification/tb_clkgen.sv
/* Testbench clock and reset */

`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rstn_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rstn_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rstn_o = 1'b1;
  end

endmodule

//--- verification/rv_decoder_asserts.sv
/* Decode stage checks */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decoder_asserts (
  input logic                     clk_i,
  input logic                     rstn_i,
  input logic [`RV_XLEN-1:0]      instr_i,
  input logic [`RV_XLEN-1:0]      instr_addr_i,
  input logic                     instr_valid_i,
  input logic                     ready_o,
  input logic                     jmp_o,
  input logic [`RV_XLEN-1:0]      jmp_addr_o,
  input logic [`RV_XLEN-1:0]      instr_addr_o,
  input logic                     illegal_o,
  input rv_decode_pkg::alu_ctrl_t alu_o,
  input rv_decode_pkg::lsu_ctrl_t lsu_o
);

  int unsigned fail_cnt = 0;  // Failed checks so far

  logic [6:0] opc;
  logic       acc;
  logic       is_op;
  logic       is_opimm;
  logic       is_ls;
  logic       alu_like;
  logic       legal;
  logic       is_shift;
  logic       stall_seen;
  logic       jalr_wait;

  assign opc      = instr_i[6:0];
  assign acc      = instr_valid_i && ready_o;
  assign is_op    = (opc == 7'h33);
  assign is_opimm = (opc == 7'h13);
  assign is_ls    = (opc == 7'h03) || (opc == 7'h23);
  assign alu_like = is_op || is_opimm || is_ls;
  assign legal    = alu_like || (opc == 7'h37) || (opc == 7'h17) ||
                    (opc == 7'h6f) || (opc == 7'h67);
  assign is_shift = (instr_i[13:12] == 2'b01);
  assign stall_seen = instr_valid_i && !ready_o && alu_like;
  assign jalr_wait  = instr_valid_i && (opc == 7'h67) && !ready_o;

  //////////////////////////////////////////////////////////////
  // Expected immediates
  //////////////////////////////////////////////////////////////
  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] opimm_imm(input logic [31:0] w);
    if (w[13:12] == 2'b01) begin
      return {27'b0, w[24:20]};  // Zero-extended shamt
    end
    return sext12(w[31:20]);
  endfunction

  function automatic logic [31:0] jal_imm(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic rv_decode_pkg::alu_ctrl_t no_pulses(input rv_decode_pkg::alu_ctrl_t a);
    rv_decode_pkg::alu_ctrl_t r;
    r = a;
    r.use_pc = 1'b0;
    r.use_alu_jmp_addr = 1'b0;
    return r;
  endfunction

  //////////////////////////////////////////////////////////////
  // Reset and idle
  //////////////////////////////////////////////////////////////
  a_reset: assert property (@(posedge clk_i) !$past(rstn_i) |->
    !jmp_o && !illegal_o && !alu_o.wb && !lsu_o.new_req && !alu_o.use_pc &&
    !alu_o.use_alu_jmp_addr && (instr_valid_i || ready_o))
    else begin fail_cnt++; $error("outputs not cleared by reset"); end

  a_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(!instr_valid_i) && $past(rstn_i) |->
    !alu_o.use_pc && !alu_o.use_alu_jmp_addr && lsu_o == $past(lsu_o) &&
    illegal_o == $past(illegal_o) && no_pulses(alu_o) == no_pulses($past(alu_o)))
    else begin fail_cnt++; $error("idle cycle changed held outputs"); end

  a_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(rstn_i) |-> instr_addr_o == $past(instr_addr_i))
    else begin fail_cnt++; $error("instr_addr_o not delayed by one cycle"); end

  //////////////////////////////////////////////////////////////
  // ALU and LSU decode
  //////////////////////////////////////////////////////////////
  a_op: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && is_op) |->
    alu_o.alu_sel == {$past(instr_i[30]), $past(instr_i[14:12])} &&
    alu_o.rf_addr_a == $past(instr_i[19:15]) && alu_o.rf_addr_b == $past(instr_i[24:20]) &&
    alu_o.op_a && alu_o.op_b &&
    alu_o.dest_addr == $past(instr_i[11:7]) && alu_o.wb && !alu_o.is_imm)
    else begin fail_cnt++; $error("OP decode mismatch"); end

  a_opimm: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && is_opimm) |->
    alu_o.alu_sel == {$past(is_shift && instr_i[30]), $past(instr_i[14:12])} &&
    alu_o.rf_addr_a == $past(instr_i[19:15]) && alu_o.dest_addr == $past(instr_i[11:7]) &&
    alu_o.wb && alu_o.is_imm && alu_o.imm_ext == opimm_imm($past(instr_i)))
    else begin fail_cnt++; $error("OP-IMM decode mismatch"); end

  a_upper: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && (opc == 7'h37 || opc == 7'h17)) |->
    alu_o.imm_ext == {$past(instr_i[31:12]), 12'b0} && alu_o.alu_sel == 4'b0000 &&
    alu_o.use_pc == $past(opc == 7'h17) && alu_o.wb && alu_o.dest_addr == $past(instr_i[11:7]))
    else begin fail_cnt++; $error("LUI or AUIPC decode mismatch"); end

  a_lsu: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && is_ls) |->
    lsu_o.new_req && lsu_o.ctrl == {$past(instr_i[6]), $past(instr_i[14:12])} &&
    ($past(instr_i[5]) || lsu_o.regdest == $past(instr_i[11:7])) &&
    alu_o.imm_ext == ($past(instr_i[5]) ?
      sext12({$past(instr_i[31:25]), $past(instr_i[11:7])}) : sext12($past(instr_i[31:20]))))
    else begin fail_cnt++; $error("load or store decode mismatch"); end

  //////////////////////////////////////////////////////////////
  // Hazards
  //////////////////////////////////////////////////////////////
  a_raw_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && instr_i[11:7] != 5'd0 && opc != 7'h23) && $past(rstn_i) &&
    instr_valid_i && alu_like &&
    (instr_i[19:15] == $past(instr_i[11:7]) ||
     (is_op && instr_i[24:20] == $past(instr_i[11:7]))) |-> !ready_o)
    else begin fail_cnt++; $error("read-after-write not stalled"); end

  a_no_x0_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(acc && (instr_i[11:7] == 5'd0 || opc == 7'h23)) && $past(rstn_i) &&
    instr_valid_i && alu_like |-> ready_o)
    else begin fail_cnt++; $error("stall after an instruction that writes no register"); end

  a_one_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(stall_seen) && instr_valid_i |-> ready_o)
    else begin fail_cnt++; $error("stall lasted longer than one cycle"); end

  a_bubble: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(stall_seen) |-> !alu_o.wb && !lsu_o.new_req)
    else begin fail_cnt++; $error("stall cycle was not a bubble"); end

  //////////////////////////////////////////////////////////////
  // Jumps and illegal opcodes
  //////////////////////////////////////////////////////////////
  a_jal_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && opc == 7'h6f |-> ready_o && jmp_o && jmp_addr_o == jal_imm(instr_i))
    else begin fail_cnt++; $error("JAL jump request mismatch"); end

  a_jal_link: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(instr_valid_i && opc == 7'h6f) |->
    alu_o.use_pc && alu_o.wb && alu_o.imm_ext == 32'd4 && alu_o.alu_sel == 4'b0000 &&
    alu_o.dest_addr == $past(instr_i[11:7]))
    else begin fail_cnt++; $error("JAL link write mismatch"); end

  a_jalr_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && opc == 7'h67 && ready_o |->
    $past(jalr_wait, 1) && $past(jalr_wait, 2) && !$past(jalr_wait, 3))
    else begin fail_cnt++; $error("JALR did not hold ready low for two cycles"); end

  a_jalr_link: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(jalr_wait) && !$past(jalr_wait, 2) |->
    alu_o.use_pc && alu_o.wb && alu_o.imm_ext == 32'd4)
    else begin fail_cnt++; $error("JALR link write mismatch"); end

  a_jalr_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(jalr_wait) && $past(jalr_wait, 2) |->
    alu_o.op_a && !alu_o.wb && alu_o.rf_addr_a == $past(instr_i[19:15]) &&
    alu_o.imm_ext == sext12($past(instr_i[31:20])))
    else begin fail_cnt++; $error("JALR target step mismatch"); end

  a_jalr_jmp: assert property (@(posedge clk_i) disable iff (!rstn_i)
    alu_o.use_alu_jmp_addr == $past(instr_valid_i && opc == 7'h67 && ready_o))
    else begin fail_cnt++; $error("ALU jump select not a single cycle after JALR"); end

  a_illegal: assert property (@(posedge clk_i) disable iff (!rstn_i)
    instr_valid_i && !legal |-> !ready_o)
    else begin fail_cnt++; $error("illegal opcode was accepted"); end

  a_illegal_flag: assert property (@(posedge clk_i) disable iff (!rstn_i)
    $past(instr_valid_i && !legal) && $past(rstn_i) |-> illegal_o)
    else begin fail_cnt++; $error("illegal_o not raised"); end

endmodule

bind rv_decoder rv_decoder_asserts u_asserts (
  .clk_i(clk_i), .rstn_i(rstn_i), .instr_i(instr_i), .instr_addr_i(instr_addr_i),
  .instr_valid_i(instr_valid_i), .ready_o(ready_o), .jmp_o(jmp_o),
  .jmp_addr_o(jmp_addr_o), .instr_addr_o(instr_addr_o), .illegal_o(illegal_o),
  .alu_o(alu_o), .lsu_o(lsu_o)
);

//--- verification/rv_decoder_tb.sv
/* Decode stage testbench */

`timescale 1ns/1ps
`include "rv_decode_params.svh"

module rv_decoder_tb;

  localparam int unsigned MAX_CYCLES = 400;  // About 60 instructions plus stalls

  logic                     clk;
  logic                     rstn;
  logic [`RV_XLEN-1:0]      instr_i;
  logic [`RV_XLEN-1:0]      instr_addr_i;
  logic                     instr_valid_i;
  logic                     ready_o;
  logic                     jmp_o;
  logic [`RV_XLEN-1:0]      jmp_addr_o;
  logic [`RV_XLEN-1:0]      instr_addr_o;
  logic                     illegal_o;
  rv_decode_pkg::alu_ctrl_t alu_o;
  rv_decode_pkg::lsu_ctrl_t lsu_o;

  logic [31:0] rng;
  logic [31:0] pc;
  int unsigned cycles;

  tb_clkgen u_clkgen (.clk_o(clk), .rstn_o(rstn));

  rv_decoder dut (
    .clk_i(clk), .rstn_i(rstn), .instr_i, .instr_addr_i, .instr_valid_i,
    .ready_o, .jmp_o, .jmp_addr_o, .instr_addr_o, .illegal_o, .alu_o, .lsu_o
  );

  //////////////////////////////////////////////////////////////
  // Random numbers and encoders
  //////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] draw();
    rng = lcg_next(rng);
    return rng;
  endfunction

  function automatic logic [31:0] enc_r(input logic b30, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  //////////////////////////////////////////////////////////////
  // Drive tasks entered and left on a falling edge
  //////////////////////////////////////////////////////////////
  task automatic issue_instr(input logic [31:0] word);
    logic taken;
    instr_i       = word;
    instr_addr_i  = pc;
    instr_valid_i = 1'b1;
    taken         = 1'b0;
    while (!taken) begin
      #1 taken = ready_o;  // Settled well before the rising edge
      @(negedge clk);
    end
    pc = pc + 32'd4;
  endtask

  task automatic idle_cycles(input int n);
    instr_valid_i = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic present_illegal(input logic [31:0] word);
    instr_i       = word;
    instr_addr_i  = pc;
    instr_valid_i = 1'b1;
    repeat (2) @(negedge clk);
    instr_valid_i = 1'b0;
  endtask

  task automatic random_instr();
    logic [31:0] r;
    logic [2:0]  f3;
    r  = draw();
    f3 = r[10:8];
    case (r[15:13])
      3'd0: issue_instr(enc_r((f3 == 3'd0 || f3 == 3'd5) && r[3], r[20:16], r[25:21], f3,
                              r[30:26]));
      3'd1: issue_instr(enc_i(r[31:20], r[25:21], (f3[1:0] == 2'b01) ? 3'd0 : f3, r[7:3],
                              7'h13));
      3'd2: issue_instr(enc_i({1'b0, r[2] & f3[2], 5'b0, r[20:16]}, r[25:21],
                              {f3[2], 2'b01}, r[30:26], 7'h13));
      3'd3: issue_instr({r[31:12], r[7:3], 7'h37});
      3'd4: issue_instr({r[31:12], r[7:3], 7'h17});
      3'd5: issue_instr(enc_i(r[31:20], r[25:21], f3, r[7:3], 7'h03));
      3'd6: issue_instr(enc_s(r[31:20], r[20:16], r[25:21], {1'b0, f3[1:0]}));
      default: issue_instr({r[31:12], r[7:3], 7'h6f});
    endcase
    if (r[0] && r[1]) begin
      idle_cycles(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  // Failure watch and cycle limit
  always @(negedge clk) begin
    cycles = cycles + 1;
    if (dut.u_asserts.fail_cnt != 0) begin
      report_failure("a DUT check failed");
    end else if (cycles > MAX_CYCLES) begin
      report_failure("timeout, the run did not finish in time");
    end
  end

  initial begin
    instr_i       = '0;
    instr_addr_i  = '0;
    instr_valid_i = 1'b0;
    rng           = 32'hb45a_f0cf;
    pc            = 32'h0000_0100;
    cycles        = 0;
    wait (rstn === 1'b1);
    @(negedge clk);
    idle_cycles(2);

    // Directed hazards on x5 and x0
    issue_instr(enc_i(12'd1, 5'd0, 3'd0, 5'd5, 7'h13));
    issue_instr(enc_r(1'b0, 5'd7, 5'd5, 3'd0, 5'd6));
    issue_instr(enc_r(1'b1, 5'd6, 5'd9, 3'd0, 5'd8));
    issue_instr(enc_i(12'd3, 5'd0, 3'd0, 5'd0, 7'h13));
    issue_instr(enc_r(1'b0, 5'd2, 5'd0, 3'd4, 5'd1));
    issue_instr(enc_s(12'h8f3, 5'd4, 5'd3, 3'd2));

    // Jumps
    issue_instr({20'h80a5c, 5'd1, 7'h6f});
    issue_instr(enc_i(12'hff0, 5'd1, 3'd0, 5'd2, 7'h67));
    issue_instr(enc_i(12'h010, 5'd3, 3'd0, 5'd0, 7'h67));
    issue_instr(enc_r(1'b0, 5'd11, 5'd12, 3'd7, 5'd13));

    // AUIPC raises use_pc and the idle cycle after it clears the flag
    issue_instr({20'h000a5, 5'd14, 7'h17});
    idle_cycles(1);

    // Illegal opcode and idle hold
    present_illegal(32'h0000_0063);
    idle_cycles(3);

    repeat (48) random_instr();
    idle_cycles(3);

    if (dut.u_asserts.fail_cnt != 0) begin
      $display("** Error at %0t ns: a DUT check failed", $time);
      $display("TEST FAIL");
      $fatal(1, "run stopped");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- rv_decode.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/hazard_detect.sv
rtl/issue_fsm.sv
rtl/ctrl_decode.sv
rtl/rv_decoder.sv
verification/tb_clkgen.sv
verification/rv_decoder_asserts.sv
verification/rv_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it.
# The run passes only if the simulation output contains the pass message.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --assert --top-module rv_decoder_tb -f rv_decode.f -o vsim &&
./obj_dir/vsim | tee /dev/stderr | grep -q "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
